/* include/wb_backplane_macros.svh */
// bus widths, slave count, i/o page window bases and memory boundary

`ifndef WB_BACKPLANE_MACROS_SVH
`define WB_BACKPLANE_MACROS_SVH

//*********************************************************************
// shared bus geometry
//*********************************************************************
`define WB_DW         16              // data word width
`define WB_AW         16              // byte address width
`define WB_NSLV       5               // ram + four i/o page devices

//*********************************************************************
// main memory, everything below the 160000 page
//*********************************************************************
`define RAM_TOP_W     3               // address bits 15..13
`define RAM_TOP_BITS  3'b111          // top 8 KB is the i/o page

//*********************************************************************
// i/o page windows, base plus count of matching upper bits
//*********************************************************************
// console uart, 177560..177566
`define UART_BASE     16'o177560
`define UART_NBITS    13              // 8 bytes
// printer, 177514..177516
`define LPT_BASE      16'o177514
`define LPT_NBITS     14              // 4 bytes
// rk11 disk controller registers, 177400..177416
`define RK_BASE       16'o177400
`define RK_NBITS      12              // 16 bytes
// my floppy controller, 172140..172142
`define MY_BASE       16'o172140
`define MY_NBITS      14              // 4 bytes

`endif

/* src/wb_backplane_pkg.sv */
// bus vector types, slave index enum and grant enum of the backplane

`include "wb_backplane_macros.svh"

package wb_backplane_pkg;

   //******************************************************************
   // bus vectors
   //******************************************************************
   typedef logic [`WB_AW-1:0]   wb_adr_t;   // byte address
   typedef logic [`WB_DW-1:0]   wb_dat_t;   // data word
   typedef logic [`WB_DW/8-1:0] wb_sel_t;   // byte lanes, [1] high byte

   // one bit per slave, indexed by slv_idx_e
   typedef logic [`WB_NSLV-1:0] slv_sel_t;

   //******************************************************************
   // slave positions
   //******************************************************************
   // order is fixed, the strobe and data vectors follow it
   typedef enum logic [2:0] {
      RAM  = 3'd0,   // main memory
      UART = 3'd1,   // console port
      LPT  = 3'd2,   // printer
      RK   = 3'd3,   // rk11 registers
      MY   = 3'd4    // my floppy registers
   } slv_idx_e;

   //******************************************************************
   // bus owner
   //******************************************************************
   typedef enum logic [1:0] {
      GNT_CPU = 2'd0,   // processor, default owner
      GNT_RK  = 2'd1,   // rk11 dma
      GNT_MY  = 2'd2    // my dma
   } grant_e;

endpackage

/* src/wb_bus_if.sv */
// shared wishbone bus between arbiter, address decoder and top level

`timescale 1ns/1ps

interface wb_bus_if;

   wb_backplane_pkg::wb_adr_t adr;    // byte address
   wb_backplane_pkg::wb_dat_t wdat;   // write data from the master
   logic                      cyc;    // bus cycle, whole transfer
   logic                      stb;    // data strobe
   logic                      we;     // 1 = write
   wb_backplane_pkg::wb_sel_t sel;    // byte lanes

   // granted master side, driven by the arbiter mux
   modport master (
      output adr,
      output wdat,
      output cyc,
      output stb,
      output we,
      output sel
   );

   // listeners, decoder and top-level outputs
   modport monitor (
      input adr,
      input wdat,
      input cyc,
      input stb,
      input we,
      input sel
   );

endinterface

/* src/bus_master_arbiter.sv */
// bus grant register with fixed dma priority and master-to-bus mux

`timescale 1ns/1ps

module bus_master_arbiter (
   input  logic                      wb_clk,
   input  logic                      rst_n_i,     // sync, active low

   // processor
   input  wb_backplane_pkg::wb_adr_t cpu_adr_i,
   input  wb_backplane_pkg::wb_dat_t cpu_dat_i,
   input  logic                      cpu_cyc_i,
   input  logic                      cpu_stb_i,
   input  logic                      cpu_we_i,
   input  wb_backplane_pkg::wb_sel_t cpu_sel_i,

   // rk11 dma, request doubles as cycle
   input  logic                      rk_req_i,
   input  wb_backplane_pkg::wb_adr_t rk_adr_i,
   input  wb_backplane_pkg::wb_dat_t rk_dat_i,
   input  logic                      rk_stb_i,
   input  logic                      rk_we_i,

   // my dma, same scheme
   input  logic                      my_req_i,
   input  wb_backplane_pkg::wb_adr_t my_adr_i,
   input  wb_backplane_pkg::wb_dat_t my_dat_i,
   input  logic                      my_stb_i,
   input  logic                      my_we_i,

   wb_bus_if.master                  bus,
   output wb_backplane_pkg::grant_e  grant_o
);

   wb_backplane_pkg::grant_e grant_q;     // current bus owner
   wb_backplane_pkg::grant_e grant_nxt;   // winner among requests

   //******************************************************************
   // fixed priority, rk over my over cpu
   //******************************************************************
   always_comb begin
      if (rk_req_i) begin
         grant_nxt = wb_backplane_pkg::GNT_RK;
      end else if (my_req_i) begin
         grant_nxt = wb_backplane_pkg::GNT_MY;
      end else begin
         grant_nxt = wb_backplane_pkg::GNT_CPU;   // nobody asks, cpu gets it back
      end
   end

   // owner switches only between cycles
   // a dma owner holds cyc through its request, so it keeps the bus
   always_ff @(posedge wb_clk) begin
      if (!rst_n_i) begin
         grant_q <= wb_backplane_pkg::GNT_CPU;
      end else if (!bus.cyc) begin
         grant_q <= grant_nxt;
      end
   end

   assign grant_o = grant_q;

   //******************************************************************
   // master switch onto the shared bus
   //******************************************************************
   always_comb begin
      case (grant_q)
         wb_backplane_pkg::GNT_RK: begin
            bus.adr  = rk_adr_i;
            bus.wdat = rk_dat_i;
            bus.cyc  = rk_req_i;   // request is the cycle
            bus.stb  = rk_stb_i;
            bus.we   = rk_we_i;
            bus.sel  = '1;         // dma moves whole words
         end
         wb_backplane_pkg::GNT_MY: begin
            bus.adr  = my_adr_i;
            bus.wdat = my_dat_i;
            bus.cyc  = my_req_i;
            bus.stb  = my_stb_i;
            bus.we   = my_we_i;
            bus.sel  = '1;
         end
         default: begin            // processor
            bus.adr  = cpu_adr_i;
            bus.wdat = cpu_dat_i;
            bus.cyc  = cpu_cyc_i;
            bus.stb  = cpu_stb_i;
            bus.we   = cpu_we_i;
            bus.sel  = cpu_sel_i;  // byte access allowed
         end
      endcase
   end

endmodule

/* src/io_page_decoder.sv */
// shared address to one-hot slave strobes for memory and i/o page devices

`timescale 1ns/1ps

`include "wb_backplane_macros.svh"

module io_page_decoder (
   wb_bus_if.monitor                  bus,
   output wb_backplane_pkg::slv_sel_t slv_sel_o
);

   logic bus_act;   // live transfer on the bus

   // window match, only the upper nbits are compared
   function automatic logic win_hit(
      input wb_backplane_pkg::wb_adr_t adr,
      input wb_backplane_pkg::wb_adr_t base,
      input int unsigned               nbits
   );
      return ((adr ^ base) >> (`WB_AW - nbits)) == '0;
   endfunction

   assign bus_act = bus.cyc & bus.stb;

   //******************************************************************
   // strobe generation
   //******************************************************************
   always_comb begin
      slv_sel_o = '0;   // no strobe outside a transfer
      if (bus_act) begin
         // memory covers 000000..157776
         slv_sel_o[wb_backplane_pkg::RAM] =
            bus.adr[`WB_AW-1 -: `RAM_TOP_W] != `RAM_TOP_BITS;

         // i/o page, all windows sit above 160000
         slv_sel_o[wb_backplane_pkg::UART] =
            win_hit(bus.adr, `UART_BASE, `UART_NBITS);   // 177560
         slv_sel_o[wb_backplane_pkg::LPT] =
            win_hit(bus.adr, `LPT_BASE, `LPT_NBITS);     // 177514
         slv_sel_o[wb_backplane_pkg::RK] =
            win_hit(bus.adr, `RK_BASE, `RK_NBITS);       // 177400
         slv_sel_o[wb_backplane_pkg::MY] =
            win_hit(bus.adr, `MY_BASE, `MY_NBITS);       // 172140
      end
   end

   // unmapped i/o page addresses leave every bit low, so no ack ever
   // comes back and the master hangs until its own bus timeout

endmodule

/* src/response_merge.sv */
// acknowledge merge with routing to the owner, plus read data mux

`timescale 1ns/1ps

`include "wb_backplane_macros.svh"

module response_merge (
   input  wb_backplane_pkg::grant_e   grant_i,
   input  wb_backplane_pkg::slv_sel_t slv_sel_i,
   input  logic [`WB_NSLV-1:0]        slv_ack_i,
   input  wb_backplane_pkg::wb_dat_t  slv_dat_i [`WB_NSLV],   // by slv_idx_e

   output wb_backplane_pkg::wb_dat_t  rdat_o,
   output logic                       cpu_ack_o,
   output logic                       rk_ack_o,
   output logic                       my_ack_o
);

   logic ack_any;   // some slave answered

   //******************************************************************
   // acknowledge path
   //******************************************************************
   // slaves only ack on their own strobe, plain or is enough
   assign ack_any = |slv_ack_i;

   // only the owner sees the ack, the others keep waiting
   assign cpu_ack_o = ack_any & (grant_i == wb_backplane_pkg::GNT_CPU);
   assign rk_ack_o  = ack_any & (grant_i == wb_backplane_pkg::GNT_RK);
   assign my_ack_o  = ack_any & (grant_i == wb_backplane_pkg::GNT_MY);

   //******************************************************************
   // read data
   //******************************************************************
   always_comb begin
      rdat_o = '0;                      // zero when nothing selected
      for (int i = 0; i < `WB_NSLV; i++) begin
         if (slv_sel_i[i]) begin
            rdat_o = rdat_o | slv_dat_i[i];   // one-hot, or acts as mux
         end
      end
   end

endmodule

/* src/wb_backplane.sv */
// backplane top level, arbiter, decoder and response merge on one wishbone bus

`timescale 1ns/1ps

`include "wb_backplane_macros.svh"

module wb_backplane (
   input  logic                      wb_clk,
   input  logic                      rst_n_i,

   // processor master
   input  wb_backplane_pkg::wb_adr_t cpu_adr_i,
   input  wb_backplane_pkg::wb_dat_t cpu_dat_i,
   input  logic                      cpu_cyc_i,
   input  logic                      cpu_stb_i,
   input  logic                      cpu_we_i,
   input  wb_backplane_pkg::wb_sel_t cpu_sel_i,

   // rk11 dma master
   input  logic                      rk_req_i,
   input  wb_backplane_pkg::wb_adr_t rk_adr_i,
   input  wb_backplane_pkg::wb_dat_t rk_wdat_i,    // write data from the dma
   input  logic                      rk_stb_i,
   input  logic                      rk_we_i,

   // my dma master
   input  logic                      my_req_i,
   input  wb_backplane_pkg::wb_adr_t my_adr_i,
   input  wb_backplane_pkg::wb_dat_t my_wdat_i,
   input  logic                      my_stb_i,
   input  logic                      my_we_i,

   // who owns the bus
   output logic                      cpu_gnt_o,
   output logic                      rk_gnt_o,
   output logic                      my_gnt_o,

   // back to the masters
   output logic                      cpu_ack_o,
   output logic                      rk_ack_o,
   output logic                      my_ack_o,
   output wb_backplane_pkg::wb_dat_t rdat_o,

   // shared bus towards the slaves
   output wb_backplane_pkg::wb_adr_t bus_adr_o,
   output wb_backplane_pkg::wb_dat_t bus_dat_o,
   output logic                      bus_we_o,
   output wb_backplane_pkg::wb_sel_t bus_sel_o,

   // slave strobes
   output logic                      ram_stb_o,
   output logic                      uart_stb_o,
   output logic                      lpt_stb_o,
   output logic                      rk_stb_o,
   output logic                      my_stb_o,

   // slave responses
   input  logic                      ram_ack_i,
   input  logic                      uart_ack_i,
   input  logic                      lpt_ack_i,
   input  logic                      rk_ack_i,
   input  logic                      my_ack_i,
   input  wb_backplane_pkg::wb_dat_t ram_dat_i,
   input  wb_backplane_pkg::wb_dat_t uart_dat_i,
   input  wb_backplane_pkg::wb_dat_t lpt_dat_i,
   input  wb_backplane_pkg::wb_dat_t rk_dat_i,     // rk11 register read data
   input  wb_backplane_pkg::wb_dat_t my_dat_i
);

   wb_backplane_pkg::grant_e   grant;                  // arbiter state
   wb_backplane_pkg::slv_sel_t slv_sel;                // one-hot strobes
   logic [`WB_NSLV-1:0]        slv_ack;                // acks by slave index
   wb_backplane_pkg::wb_dat_t  slv_dat [`WB_NSLV];     // read data by index

   wb_bus_if bus_if ();   // shared bus

   //******************************************************************
   // arbitration and master switch (stage 1)
   //******************************************************************
   bus_master_arbiter i_arbiter (
      .wb_clk    (wb_clk),
      .rst_n_i   (rst_n_i),
      .cpu_adr_i (cpu_adr_i),
      .cpu_dat_i (cpu_dat_i),
      .cpu_cyc_i (cpu_cyc_i),
      .cpu_stb_i (cpu_stb_i),
      .cpu_we_i  (cpu_we_i),
      .cpu_sel_i (cpu_sel_i),
      .rk_req_i  (rk_req_i),
      .rk_adr_i  (rk_adr_i),
      .rk_dat_i  (rk_wdat_i),
      .rk_stb_i  (rk_stb_i),
      .rk_we_i   (rk_we_i),
      .my_req_i  (my_req_i),
      .my_adr_i  (my_adr_i),
      .my_dat_i  (my_wdat_i),
      .my_stb_i  (my_stb_i),
      .my_we_i   (my_we_i),
      .bus       (bus_if.master),
      .grant_o   (grant)
   );

   // enum decoded for the masters
   assign cpu_gnt_o = (grant == wb_backplane_pkg::GNT_CPU);
   assign rk_gnt_o  = (grant == wb_backplane_pkg::GNT_RK);
   assign my_gnt_o  = (grant == wb_backplane_pkg::GNT_MY);

   // bus lines straight out to the slaves
   assign bus_adr_o = bus_if.adr;
   assign bus_dat_o = bus_if.wdat;
   assign bus_we_o  = bus_if.we;
   assign bus_sel_o = bus_if.sel;

   //******************************************************************
   // address decode (stage 2)
   //******************************************************************
   io_page_decoder i_decoder (
      .bus       (bus_if.monitor),
      .slv_sel_o (slv_sel)
   );

   assign ram_stb_o  = slv_sel[wb_backplane_pkg::RAM];
   assign uart_stb_o = slv_sel[wb_backplane_pkg::UART];
   assign lpt_stb_o  = slv_sel[wb_backplane_pkg::LPT];
   assign rk_stb_o   = slv_sel[wb_backplane_pkg::RK];
   assign my_stb_o   = slv_sel[wb_backplane_pkg::MY];

   //******************************************************************
   // response merge (stage 3)
   //******************************************************************
   // slave answers gathered in slave index order
   assign slv_ack[wb_backplane_pkg::RAM]  = ram_ack_i;
   assign slv_ack[wb_backplane_pkg::UART] = uart_ack_i;
   assign slv_ack[wb_backplane_pkg::LPT]  = lpt_ack_i;
   assign slv_ack[wb_backplane_pkg::RK]   = rk_ack_i;
   assign slv_ack[wb_backplane_pkg::MY]   = my_ack_i;

   assign slv_dat[wb_backplane_pkg::RAM]  = ram_dat_i;
   assign slv_dat[wb_backplane_pkg::UART] = uart_dat_i;
   assign slv_dat[wb_backplane_pkg::LPT]  = lpt_dat_i;
   assign slv_dat[wb_backplane_pkg::RK]   = rk_dat_i;
   assign slv_dat[wb_backplane_pkg::MY]   = my_dat_i;

   response_merge i_merge (
      .grant_i   (grant),
      .slv_sel_i (slv_sel),
      .slv_ack_i (slv_ack),
      .slv_dat_i (slv_dat),
      .rdat_o    (rdat_o),
      .cpu_ack_o (cpu_ack_o),
      .rk_ack_o  (rk_ack_o),
      .my_ack_o  (my_ack_o)
   );

endmodule

/* verif/tb_clock_gen.sv */
// free running testbench clock source

`timescale 1ns/1ps

module tb_clock_gen #(
   parameter int period_ns = 100   // full clock period
) (
   output logic clk_o
);

   // starts low, first rising edge after half a period
   initial begin
      clk_o = 1'b0;
      forever begin
         #(period_ns / 2);
         clk_o = ~clk_o;
      end
   end

endmodule

/* verif/tb_wb_backplane.sv */
// backplane testbench with random masters, slave and grant model, checks and timeout

`timescale 1ns/1ps

module tb_wb_backplane;

   //******************************************************************
   // run length
   //******************************************************************
   localparam int n_dec   = 200;   // decode vectors
   localparam int n_rd    = 100;   // cpu reads
   localparam int n_dma   = 40;    // dma rounds of 3 cycles
   localparam int n_bp    = 20;    // stall rounds of up to 12 cycles
   localparam int max_cyc = 4 + n_dec + n_rd + 1 + 3 * n_dma + 14 * n_bp + 50;
   localparam int chk_dly = 40;    // check point 10 ns before the rising edge

   localparam logic [1:0] g_cpu = 2'd0;
   localparam logic [1:0] g_rk  = 2'd1;
   localparam logic [1:0] g_my  = 2'd2;

   logic        wb_clk;
   logic        rst_n_i;
   logic [15:0] cpu_adr_i, cpu_dat_i;
   logic        cpu_cyc_i, cpu_stb_i, cpu_we_i;
   logic [1:0]  cpu_sel_i;
   logic [15:0] rk_adr_i, my_adr_i;
   logic [15:0] rk_wdat_i, my_wdat_i;
   logic        rk_req_i, rk_stb_i, rk_we_i;
   logic        my_req_i, my_stb_i, my_we_i;
   logic        cpu_gnt_o, rk_gnt_o, my_gnt_o;
   logic        cpu_ack_o, rk_ack_o, my_ack_o;
   logic [15:0] rdat_o, bus_adr_o, bus_dat_o;
   logic        bus_we_o;
   logic [1:0]  bus_sel_o;
   logic        ram_stb_o, uart_stb_o, lpt_stb_o, rk_stb_o, my_stb_o;
   logic        ram_ack_i, uart_ack_i, lpt_ack_i, rk_ack_i, my_ack_i;
   logic [15:0] ram_dat_i, uart_dat_i, lpt_dat_i, rk_dat_i, my_dat_i;

   logic [4:0]  stb_vec;           // strobes in slave index order
   logic        hold_ack;          // all slaves stall while set
   logic [1:0]  exp_grant;         // grant model
   logic        model_cyc;         // shared cyc as the model sees it
   integer      seed;
   int          err_cnt = 0;
   int          chk_cnt = 0;
   int          cycle_cnt = 0;

   tb_clock_gen #(.period_ns(100)) i_clk_gen (.clk_o(wb_clk));

   wb_backplane i_wb_backplane (.*);

   assign stb_vec = {my_stb_o, rk_stb_o, lpt_stb_o, uart_stb_o, ram_stb_o};

   //******************************************************************
   // slave model
   //******************************************************************
   // zero wait state ack unless stalled
   assign ram_ack_i  = ram_stb_o & ~hold_ack;
   assign uart_ack_i = uart_stb_o & ~hold_ack;
   assign lpt_ack_i  = lpt_stb_o & ~hold_ack;
   assign rk_ack_i   = rk_stb_o & ~hold_ack;
   assign my_ack_i   = my_stb_o & ~hold_ack;

   // slave index on top of the low address bits
   assign ram_dat_i  = {4'd0, bus_adr_o[11:0]};
   assign uart_dat_i = {4'd1, bus_adr_o[11:0]};
   assign lpt_dat_i  = {4'd2, bus_adr_o[11:0]};
   assign rk_dat_i   = {4'd3, bus_adr_o[11:0]};
   assign my_dat_i   = {4'd4, bus_adr_o[11:0]};

   //******************************************************************
   // grant model
   //******************************************************************
   assign model_cyc = (exp_grant == g_rk) ? rk_req_i :
                      (exp_grant == g_my) ? my_req_i : cpu_cyc_i;

   always @(posedge wb_clk) begin
      if (!rst_n_i) begin
         exp_grant <= g_cpu;
      end else if (!model_cyc) begin   // owner changes between cycles only
         exp_grant <= rk_req_i ? g_rk : (my_req_i ? g_my : g_cpu);
      end
   end

   // run limit from the test lengths
   always @(posedge wb_clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= max_cyc) begin
         $display("timeout, tests still running after %0d cycles", cycle_cnt);
         $display("Something failed");
         $finish;
      end
   end

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      chk_cnt++;
      if (actual !== expected) begin
         err_cnt++;
         $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
      end
   endtask

   task automatic check_grant();
      check_value("cpu_gnt_o", 32'(cpu_gnt_o), 32'(exp_grant == g_cpu));
      check_value("rk_gnt_o", 32'(rk_gnt_o), 32'(exp_grant == g_rk));
      check_value("my_gnt_o", 32'(my_gnt_o), 32'(exp_grant == g_my));
   endtask

   task automatic end_test(input string name, input int err_start);
      $display("test %s finished, %0d errors", name, err_cnt - err_start);
   endtask

   //******************************************************************
   // expected slave index per address window or -1 when unmapped
   //******************************************************************
   function automatic int exp_slave(input logic [15:0] adr);
      if (adr < 16'o160000) return 0;                             // memory
      if (adr >= 16'o177560 && adr <= 16'o177567) return 1;       // uart
      if (adr >= 16'o177514 && adr <= 16'o177517) return 2;       // printer
      if (adr >= 16'o177400 && adr <= 16'o177417) return 3;       // rk11
      if (adr >= 16'o172140 && adr <= 16'o172143) return 4;       // my
      return -1;
   endfunction

   function automatic logic [4:0] exp_stb(input logic [15:0] adr);
      int s;
      s = exp_slave(adr);
      return (s < 0) ? 5'd0 : 5'(1 << s);
   endfunction

   function automatic logic [15:0] exp_rdat(input logic [15:0] adr);
      int s;
      s = exp_slave(adr);
      return (s < 0) ? 16'd0 : {4'(s), adr[11:0]};
   endfunction

   // biased towards window edges since plain random rarely hits the i/o page
   function automatic logic [15:0] rand_adr();
      logic [31:0] r;
      r = $random(seed);
      case (r[2:0])
         3'd0, 3'd1: return r[31:16];
         3'd2:       return {3'b111, r[28:16]};               // anywhere in i/o page
         3'd3:       return 16'o177560 + 16'(r[19:16]);
         3'd4:       return 16'o177510 + 16'(r[19:16]);
         3'd5:       return 16'o177400 + 16'(r[20:16]);
         3'd6:       return 16'o172140 + 16'(r[18:16]);
         default:    return 16'o157770 + 16'(r[19:16]);       // memory top
      endcase
   endfunction

   //******************************************************************
   // test sequence
   //******************************************************************
   initial begin
      int          err_start;
      int          hold;
      logic [15:0] dma_adr;
      logic [15:0] dma_dat;
      logic        dma_we;
      logic [31:0] r;
      logic [31:0] d;
      seed      = 32'h5bee_021b;
      rst_n_i   = 1'b0;
      hold_ack  = 1'b0;
      cpu_adr_i = '0;
      cpu_dat_i = '0;
      cpu_cyc_i = 1'b0;
      cpu_stb_i = 1'b0;
      cpu_we_i  = 1'b0;
      cpu_sel_i = 2'b11;
      rk_req_i  = 1'b0;
      rk_adr_i  = '0;
      rk_wdat_i = '0;
      rk_stb_i  = 1'b0;
      rk_we_i   = 1'b0;
      my_req_i  = 1'b0;
      my_adr_i  = '0;
      my_wdat_i = '0;
      my_stb_i  = 1'b0;
      my_we_i   = 1'b0;

      // after reset the cpu owns an idle bus
      repeat (2) @(posedge wb_clk);
      @(negedge wb_clk);
      rst_n_i = 1'b1;
      #(chk_dly);
      err_start = err_cnt;
      check_grant();
      check_value("cpu_gnt_o", 32'(cpu_gnt_o), 32'd1);
      check_value("slave strobes", 32'(stb_vec), 32'd0);
      check_value("acks", 32'({cpu_ack_o, rk_ack_o, my_ack_o}), 32'd0);
      end_test("reset", err_start);

      // decode of random cpu addresses
      err_start = err_cnt;
      for (int i = 0; i < n_dec; i++) begin
         @(negedge wb_clk);
         r = $random(seed);
         cpu_adr_i = rand_adr();
         cpu_dat_i = r[15:0];
         cpu_we_i  = r[16];
         cpu_sel_i = r[18:17];
         cpu_cyc_i = 1'b1;
         cpu_stb_i = 1'b1;
         #(chk_dly);
         check_value("slave strobes", 32'(stb_vec), 32'(exp_stb(cpu_adr_i)));
         check_value("bus_adr_o", 32'(bus_adr_o), 32'(cpu_adr_i));
         check_value("bus_dat_o", 32'(bus_dat_o), 32'(cpu_dat_i));
         check_value("bus_we_o", 32'(bus_we_o), 32'(cpu_we_i));
         check_value("bus_sel_o", 32'(bus_sel_o), 32'(cpu_sel_i));
      end
      end_test("decode", err_start);

      // cpu reads through the data mux
      err_start = err_cnt;
      for (int i = 0; i < n_rd; i++) begin
         @(negedge wb_clk);
         cpu_adr_i = rand_adr();
         cpu_we_i  = 1'b0;
         cpu_sel_i = 2'b11;
         #(chk_dly);
         check_value("rdat_o", 32'(rdat_o), 32'(exp_rdat(cpu_adr_i)));
         check_value("cpu_ack_o", 32'(cpu_ack_o), 32'(exp_slave(cpu_adr_i) >= 0));
         check_value("rk_ack_o", 32'(rk_ack_o), 32'd0);
         check_value("my_ack_o", 32'(my_ack_o), 32'd0);
      end
      @(negedge wb_clk);
      cpu_cyc_i = 1'b0;
      cpu_stb_i = 1'b0;
      cpu_sel_i = 2'b01;                 // idle cpu lanes unlike the dma pair
      end_test("read", err_start);

      // dma requests on an idle bus
      err_start = err_cnt;
      for (int i = 0; i < n_dma; i++) begin
         @(negedge wb_clk);
         r = $random(seed);
         d = $random(seed);
         rk_req_i  = r[0];
         rk_stb_i  = r[0];
         my_req_i  = r[1];
         my_stb_i  = r[1];
         rk_we_i   = r[2];
         my_we_i   = r[3];
         rk_wdat_i = d[15:0];
         my_wdat_i = d[31:16];
         rk_adr_i  = rand_adr();
         my_adr_i  = rand_adr();
         #(chk_dly);
         check_grant();                  // request not yet sampled
         @(negedge wb_clk);
         #(chk_dly);
         check_grant();
         check_value("rk_gnt_o", 32'(rk_gnt_o), 32'(r[0]));
         check_value("my_gnt_o", 32'(my_gnt_o), 32'(~r[0] & r[1]));
         check_value("cpu_ack_o", 32'(cpu_ack_o), 32'd0);
         if (r[1:0] != 2'b00) begin
            dma_adr = r[0] ? rk_adr_i : my_adr_i;
            dma_dat = r[0] ? rk_wdat_i : my_wdat_i;
            dma_we  = r[0] ? r[2] : r[3];
            check_value("bus_sel_o", 32'(bus_sel_o), 32'(2'b11));
            check_value("bus_adr_o", 32'(bus_adr_o), 32'(dma_adr));
            check_value("bus_dat_o", 32'(bus_dat_o), 32'(dma_dat));
            check_value("bus_we_o", 32'(bus_we_o), 32'(dma_we));
            check_value("rdat_o", 32'(rdat_o), 32'(exp_rdat(dma_adr)));
            check_value("rk_ack_o", 32'(rk_ack_o), 32'(r[0] && exp_slave(dma_adr) >= 0));
            check_value("my_ack_o", 32'(my_ack_o), 32'(!r[0] && exp_slave(dma_adr) >= 0));
         end
         @(negedge wb_clk);
         rk_req_i = 1'b0;
         rk_stb_i = 1'b0;
         my_req_i = 1'b0;
         my_stb_i = 1'b0;
         #(chk_dly);
         check_grant();                  // released at the next edge
         check_value("slave strobes", 32'(stb_vec), 32'd0);
      end
      end_test("dma priority", err_start);

      // stalled cpu cycle keeps the bus against rk
      err_start = err_cnt;
      for (int i = 0; i < n_bp; i++) begin
         @(negedge wb_clk);
         r = $random(seed);
         hold = 1 + int'(r[2:0]);
         do begin
            cpu_adr_i = rand_adr();
         end while (exp_slave(cpu_adr_i) < 0);
         cpu_we_i  = 1'b0;
         cpu_cyc_i = 1'b1;
         cpu_stb_i = 1'b1;
         rk_req_i  = 1'b1;
         hold_ack  = 1'b1;
         for (int c = 0; c < hold; c++) begin
            #(chk_dly);
            check_grant();
            check_value("cpu_gnt_o", 32'(cpu_gnt_o), 32'd1);
            check_value("cpu_ack_o", 32'(cpu_ack_o), 32'd0);
            @(negedge wb_clk);
         end
         hold_ack = 1'b0;
         #(chk_dly);
         while (!cpu_ack_o) begin        // wait for the slave handshake
            @(negedge wb_clk);
            #(chk_dly);
         end
         @(negedge wb_clk);
         cpu_cyc_i = 1'b0;
         cpu_stb_i = 1'b0;
         #(chk_dly);
         check_value("cpu_gnt_o", 32'(cpu_gnt_o), 32'd1);   // cyc high at last edge
         @(negedge wb_clk);
         #(chk_dly);
         check_grant();
         check_value("rk_gnt_o", 32'(rk_gnt_o), 32'd1);
         @(negedge wb_clk);
         rk_req_i = 1'b0;
      end
      end_test("back-pressure", err_start);

      $display("all tests done, %0d checks, %0d errors", chk_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

/* wb_backplane.f */
+incdir+include
src/wb_backplane_pkg.sv
src/wb_bus_if.sv
src/bus_master_arbiter.sv
src/io_page_decoder.sv
src/response_merge.sv
src/wb_backplane.sv
verif/tb_clock_gen.sv
verif/tb_wb_backplane.sv

/* Makefile */
# Verilator build and run of the backplane testbench

TOP     := tb_wb_backplane
OBJ_DIR := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, pass if the pass line shows up"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing -f wb_backplane.f --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf $(OBJ_DIR)
